// ==== Bender.yml ====
package:
  name: duc_chain

export_include_dirs:
  - include

sources:
  - design/duc_pkg.sv
  - design/duc_settings.sv
  - design/duc_strober.sv
  - design/cic_interp.sv
  - design/cordic_rotator.sv
  - design/duc_chain.sv
  - target: test
    files:
      - test/duc_chain_tb.sv

// ==== design/cic_interp.sv ====
// ******************************
// CIC interpolator for I and Q,
// combs at sample rate, integrators
// at clock rate, gain shift
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module cic_interp (
   input  logic             clk,
   input  logic             rst,
   input  logic             run_i,
   input  logic             rate_change_i,
   input  duc_pkg::rate_t   rate_log2_i,
   input  logic             stb_i,
   input  duc_pkg::sample_t i_i,
   input  duc_pkg::sample_t q_i,
   output duc_pkg::sample_t i_o,
   output duc_pkg::sample_t q_o
);

   localparam int N     = `DUC_CIC_N;
   localparam int DW    = `DUC_DATA_W;
   localparam int GROW  = (N - 1) * `DUC_RATE_MAX_LOG2;  // Gain is R^(N-1)
   localparam int ACC_W = DW + GROW;
   localparam int SH_W  = $clog2(GROW + 1);

   typedef logic signed [ACC_W-1:0] acc_t;

   localparam acc_t SAT_MAX = acc_t'(2 ** (DW - 1) - 1);  // Symmetric limit

   logic             clr;
   logic             stb_d;       // Strobe delayed to line up with upstream data
   logic [N:0]       vld;         // Sample position through the comb pipe
   logic [SH_W-1:0]  shift_amt;
   acc_t             in_r     [2];
   acc_t             comb_in  [2][N];
   acc_t             comb_dly [2][N];
   acc_t             comb     [2][N];
   acc_t             integ_in [2][N];
   acc_t             integ    [2][N];
   duc_pkg::sample_t dout     [2];

   function automatic duc_pkg::sample_t saturate(input acc_t v);
      if (v > SAT_MAX)
         return duc_pkg::sample_t'(SAT_MAX);
      else if (v < -SAT_MAX)
         return duc_pkg::sample_t'(-SAT_MAX);
      else
         return duc_pkg::sample_t'(v[DW-1:0]);
   endfunction

   assign clr       = rst || !run_i || rate_change_i;  // Restart from zero state
   assign shift_amt = SH_W'((N - 1) * rate_log2_i);

   // Stage inputs: comb chain fed by the capture reg, integrators by zero stuffing
   always_comb begin
      for (int ch = 0; ch < 2; ch++) begin
         comb_in[ch][0]  = in_r[ch];
         integ_in[ch][0] = vld[N] ? comb[ch][N-1] : '0;  // Zero between samples
         for (int k = 1; k < N; k++) begin
            comb_in[ch][k]  = comb[ch][k-1];
            integ_in[ch][k] = integ[ch][k-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clr) begin
         stb_d <= 1'b0;
         vld   <= '0;
         for (int ch = 0; ch < 2; ch++) begin
            in_r[ch] <= '0;
            dout[ch] <= '0;
            for (int k = 0; k < N; k++) begin
               comb_dly[ch][k] <= '0;
               comb[ch][k]     <= '0;
               integ[ch][k]    <= '0;
            end
         end
      end else begin
         stb_d <= stb_i;
         vld   <= {vld[N-1:0], stb_d};
         if (stb_d) begin
            in_r[0] <= acc_t'(i_i);  // Sign extended
            in_r[1] <= acc_t'(q_i);
         end
         for (int ch = 0; ch < 2; ch++) begin
            for (int k = 0; k < N; k++) begin
               if (vld[k]) begin  // Comb k steps once per sample
                  comb[ch][k]     <= comb_in[ch][k] - comb_dly[ch][k];
                  comb_dly[ch][k] <= comb_in[ch][k];
               end
               integ[ch][k] <= integ[ch][k] + integ_in[ch][k];  // Wraps, exact at the end
            end
            dout[ch] <= saturate(integ[ch][N-1] >>> shift_amt);
         end
      end
   end

   assign i_o = dout[0];
   assign q_o = dout[1];

endmodule

// ==== design/cordic_rotator.sv ====
// ******************************
// Pipelined CORDIC rotator with
// quadrant pre-rotation and gain fix
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module cordic_rotator (
   input  logic                   clk,
   input  logic                   rst,
   input  duc_pkg::sample_t       x_i,
   input  duc_pkg::sample_t       y_i,
   input  logic [`DUC_ZETA_W-1:0] z_i,
   output duc_pkg::sample_t       x_o,
   output duc_pkg::sample_t       y_o
);

   localparam int DW    = `DUC_DATA_W;
   localparam int ZW    = `DUC_ZETA_W;
   localparam int NS    = `DUC_CORDIC_STAGES;
   localparam int GUARD = 4;               // Extra LSBs through the shifts
   localparam int XW    = DW + 2 + GUARD;  // Room for sqrt(2) and the 1.647 gain
   localparam int KW    = 18;
   localparam int KFRAC = 17;
   localparam int PW    = XW + KW;
   localparam int SHR   = KFRAC + GUARD;

   typedef logic signed [XW-1:0] xy_t;
   typedef logic signed [ZW-1:0] ang_t;
   typedef logic signed [PW-1:0] prod_t;

   localparam logic signed [KW-1:0] K_COMP = 18'sd79594;  // 0.60725 in Q1.17
   localparam prod_t RND = prod_t'(1) <<< (SHR - 1);
   localparam prod_t LIM = prod_t'(2 ** (DW - 1) - 1);

   // atan(2^-i) in units of 2^-24 turn
   localparam ang_t ATAN [NS] = '{
      24'sd2097152, 24'sd1238021, 24'sd654136, 24'sd332050,
      24'sd166669,  24'sd83416,   24'sd41718,  24'sd20860,
      24'sd10430,   24'sd5215,    24'sd2608,   24'sd1304,
      24'sd652,     24'sd326,     24'sd163,    24'sd81
   };

   logic [ZW-1:0] z_off;
   logic [1:0]    quad;
   ang_t          resid;
   xy_t           x_ext;
   xy_t           y_ext;
   xy_t           x_p [NS+1];
   xy_t           y_p [NS+1];
   ang_t          z_p [NS+1];
   prod_t         prod_x;
   prod_t         prod_y;

   function automatic duc_pkg::sample_t saturate(input prod_t v);
      if (v > LIM)
         return duc_pkg::sample_t'(LIM);
      else if (v < -LIM)
         return duc_pkg::sample_t'(-LIM);
      else
         return duc_pkg::sample_t'(v[DW-1:0]);
   endfunction

   // Quadrant centred on 0, 90, 180, 270 degrees
   assign z_off = z_i + ZW'(1 << (ZW - 3));
   assign quad  = z_off[ZW-1 -: 2];
   assign resid = ang_t'(z_i - {quad, {(ZW-2){1'b0}}});  // Within +-45 deg

   assign x_ext = xy_t'(x_i) <<< GUARD;
   assign y_ext = xy_t'(y_i) <<< GUARD;

   // Gain compensation on the last stage
   assign prod_x = x_p[NS] * K_COMP;
   assign prod_y = y_p[NS] * K_COMP;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i <= NS; i++) begin
            x_p[i] <= '0;
            y_p[i] <= '0;
            z_p[i] <= '0;
         end
         x_o <= '0;
         y_o <= '0;
      end else begin
         case (quad)  // Coarse rotation by multiples of 90 deg
            2'd0: begin
               x_p[0] <= x_ext;
               y_p[0] <= y_ext;
            end
            2'd1: begin
               x_p[0] <= -y_ext;
               y_p[0] <= x_ext;
            end
            2'd2: begin
               x_p[0] <= -x_ext;
               y_p[0] <= -y_ext;
            end
            default: begin
               x_p[0] <= y_ext;
               y_p[0] <= -x_ext;
            end
         endcase
         z_p[0] <= resid;
         for (int i = 0; i < NS; i++) begin
            if (!z_p[i][ZW-1]) begin  // Positive residual turns counter clockwise
               x_p[i+1] <= x_p[i] - (y_p[i] >>> i);
               y_p[i+1] <= y_p[i] + (x_p[i] >>> i);
               z_p[i+1] <= z_p[i] - ATAN[i];
            end else begin
               x_p[i+1] <= x_p[i] + (y_p[i] >>> i);
               y_p[i+1] <= y_p[i] - (x_p[i] >>> i);
               z_p[i+1] <= z_p[i] + ATAN[i];
            end
         end
         x_o <= saturate((prod_x + RND) >>> SHR);  // Round and drop guard bits
         y_o <= saturate((prod_y + RND) >>> SHR);
      end
   end

   // Pre-rotation and table leave a residual of about one finest step
   a_resid_converged : assert property (
      @(posedge clk) disable iff (rst)
         (z_p[NS] <= 2 * ATAN[NS-1]) && (z_p[NS] >= -2 * ATAN[NS-1])
   ) else $error("CORDIC residual angle did not converge");

endmodule

// ==== design/duc_chain.sv ====
// ******************************
// DUC top: settings, strober, CIC,
// NCO, CORDIC and output scaling
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module duc_chain (
   input  logic          clk,
   input  logic          rst,
   input  logic          set_stb_i,
   input  logic [7:0]    set_addr_i,
   input  logic [31:0]   set_data_i,
   input  logic          run_i,
   input  logic [31:0]   sample_i,
   output logic          strobe_o,
   output duc_pkg::out_t tx_i_o,
   output duc_pkg::out_t tx_q_o
);

   localparam int DW     = `DUC_DATA_W;
   localparam int SW     = `DUC_SAMPLE_W;
   localparam int OW     = `DUC_OUT_W;
   localparam int PW     = 2 * DW;   // 18x18 product
   localparam int OUT_HI = PW - 3;   // Bit 33, drops the Q2.16 integer headroom

   duc_pkg::phase_t  phase_inc;
   duc_pkg::phase_t  phase;
   duc_pkg::scale_t  scale;
   duc_pkg::rate_t   rate_log2;
   logic             rate_change;
   duc_pkg::sample_t smp_i;
   duc_pkg::sample_t smp_q;
   duc_pkg::sample_t cic_i;
   duc_pkg::sample_t cic_q;
   duc_pkg::sample_t rot_i;
   duc_pkg::sample_t rot_q;
   logic signed [PW-1:0] prod_i;
   logic signed [PW-1:0] prod_q;

   duc_settings i_duc_settings (
      .clk           (clk),
      .rst           (rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .phase_inc_o   (phase_inc),
      .scale_o       (scale),
      .rate_log2_o   (rate_log2),
      .rate_change_o (rate_change)
   );

   // Sample request to upstream, data due one cycle later
   duc_strober i_duc_strober (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .rate_change_i (rate_change),
      .rate_log2_i   (rate_log2),
      .strobe_o      (strobe_o)
   );

   // I in the upper half, left justified into the 18-bit path
   assign smp_i = {sample_i[2*SW-1:SW], {(DW-SW){1'b0}}};
   assign smp_q = {sample_i[SW-1:0], {(DW-SW){1'b0}}};

   cic_interp i_cic_interp (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .rate_change_i (rate_change),
      .rate_log2_i   (rate_log2),
      .stb_i         (strobe_o),
      .i_i           (smp_i),
      .q_i           (smp_q),
      .i_o           (cic_i),
      .q_o           (cic_q)
   );

   // NCO, parked at zero while stopped
   always_ff @(posedge clk) begin
      if (rst || !run_i)
         phase <= '0;
      else
         phase <= phase + phase_inc;
   end

   cordic_rotator i_cordic_rotator (
      .clk (clk),
      .rst (rst),
      .x_i (cic_i),
      .y_i (cic_q),
      .z_i (phase[`DUC_PHASE_W-1 -: `DUC_ZETA_W]),  // Top phase bits only
      .x_o (rot_i),
      .y_o (rot_q)
   );

   // Output scaling, one register
   always_ff @(posedge clk) begin
      if (rst) begin
         prod_i <= '0;
         prod_q <= '0;
      end else begin
         prod_i <= rot_i * scale;
         prod_q <= rot_q * scale;
      end
   end

   assign tx_i_o = prod_i[OUT_HI -: OW];  // Unity scale gives path value << 6
   assign tx_q_o = prod_q[OUT_HI -: OW];

endmodule

// ==== design/duc_pkg.sv ====
// ******************************
// DUC types: samples, phase, scale,
// rate and strober states
// ******************************

`include "duc_config.svh"

package duc_pkg;

   // Baseband path sample, I or Q
   typedef logic signed [`DUC_DATA_W-1:0] sample_t;

   typedef logic signed [`DUC_OUT_W-1:0] out_t;    // To the TX frontend

   // NCO phase, full turn is 2^32
   typedef logic [`DUC_PHASE_W-1:0] phase_t;

   typedef logic signed [`DUC_DATA_W-1:0] scale_t;  // Q2.16

   // log2 of the interpolation rate, 0..6
   typedef logic [2:0] rate_t;

   // Sample request strober
   typedef enum logic [1:0] {IDLE, HOLD, COUNT} strober_state_e;

endpackage

// ==== design/duc_settings.sv ====
// ******************************
// DUC settings registers
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module duc_settings (
   input  logic            clk,
   input  logic            rst,
   input  logic            set_stb_i,
   input  logic [7:0]      set_addr_i,
   input  logic [31:0]     set_data_i,
   output duc_pkg::phase_t phase_inc_o,
   output duc_pkg::scale_t scale_o,
   output duc_pkg::rate_t  rate_log2_o,
   output logic            rate_change_o
);

   localparam duc_pkg::rate_t RATE_MAX = duc_pkg::rate_t'(`DUC_RATE_MAX_LOG2);

   logic           wr_phase;
   logic           wr_scale;
   logic           wr_rate;
   duc_pkg::rate_t rate_wr;

   // Address decode, one register per address
   assign wr_phase = set_stb_i && (set_addr_i == 8'(`DUC_ADDR_PHASE));
   assign wr_scale = set_stb_i && (set_addr_i == 8'(`DUC_ADDR_SCALE));
   assign wr_rate  = set_stb_i && (set_addr_i == 8'(`DUC_ADDR_RATE));

   assign rate_wr = set_data_i[2:0];  // Low 3 bits carry log2 rate

   always_ff @(posedge clk) begin
      if (rst) begin
         phase_inc_o   <= '0;
         scale_o       <= duc_pkg::scale_t'(`DUC_SCALE_ONE);  // Unity gain out of reset
         rate_log2_o   <= '0;
         rate_change_o <= 1'b0;
      end else begin
         if (wr_phase)
            phase_inc_o <= set_data_i;
         if (wr_scale)
            scale_o <= duc_pkg::scale_t'(set_data_i[`DUC_DATA_W-1:0]);
         if (wr_rate)
            rate_log2_o <= (rate_wr > RATE_MAX) ? RATE_MAX : rate_wr;  // Clamp to 64x
         rate_change_o <= wr_rate;  // Pulse the cycle after the write
      end
   end

   // Strober and CIC restart needs isolated rate writes on the bus
   a_rate_change_single : assert property (
      @(posedge clk) disable iff (rst) rate_change_o |=> !rate_change_o
   ) else $error("rate_change_o high on two cycles in a row");

endmodule

// ==== design/duc_strober.sv ====
// ******************************
// Sample request strober,
// one pulse every 2^L cycles
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module duc_strober (
   input  logic           clk,
   input  logic           rst,
   input  logic           run_i,
   input  logic           rate_change_i,
   input  duc_pkg::rate_t rate_log2_i,
   output logic           strobe_o
);

   localparam int CNT_W = `DUC_RATE_MAX_LOG2 + 1;  // Holds 2^MAX - 1

   duc_pkg::strober_state_e state;
   logic [CNT_W-1:0]        cnt;
   logic [CNT_W-1:0]        period_m1;

   // Reload value 2^L - 1 which is zero for L = 0
   assign period_m1 = CNT_W'((1 << rate_log2_i) - 1);

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         state <= duc_pkg::IDLE;
         cnt   <= '0;
      end else if (rate_change_i) begin
         state <= duc_pkg::HOLD;  // Sit out the rate change cycle
         cnt   <= '0;
      end else begin
         case (state)
            duc_pkg::IDLE,
            duc_pkg::HOLD: begin
               state <= duc_pkg::COUNT;
               cnt   <= period_m1;  // First pulse 2^L cycles out
            end
            duc_pkg::COUNT: begin
               if (cnt == '0)
                  cnt <= period_m1;  // Wrap on the pulse
               else
                  cnt <= cnt - 1'b1;
            end
            default: begin
               state <= duc_pkg::IDLE;
               cnt   <= '0;
            end
         endcase
      end
   end

   assign strobe_o = (state == duc_pkg::COUNT) && (cnt == '0);

   // Above L = 0 the reload always leaves a gap after a pulse
   a_strobe_gap : assert property (
      @(posedge clk) disable iff (rst)
         strobe_o && (rate_log2_i != '0) |=> !strobe_o
   ) else $error("strobe_o high on two cycles in a row at a rate above 1");

endmodule

// ==== include/duc_config.svh ====
// ******************************
// DUC widths, settings addresses,
// CIC and CORDIC constants
// ******************************

`ifndef DUC_CONFIG_SVH
`define DUC_CONFIG_SVH

`define DUC_SAMPLE_W       16        // One I or Q component of the 32-bit sample word
`define DUC_DATA_W         18        // Internal path width
`define DUC_OUT_W          24        // Frontend output width
`define DUC_PHASE_W        32        // NCO accumulator
`define DUC_ZETA_W         24        // Phase bits handed to the CORDIC

// CIC setup
`define DUC_CIC_N          4
`define DUC_RATE_MAX_LOG2  6         // Interpolation up to 64

`define DUC_CORDIC_STAGES  16

// Scale is signed Q2.16, this is gain 1.0
`define DUC_SCALE_ONE      'h10000

// Settings bus map
`define DUC_BASE           0
`define DUC_ADDR_PHASE     (`DUC_BASE + 0)
`define DUC_ADDR_SCALE     (`DUC_BASE + 1)
`define DUC_ADDR_RATE      (`DUC_BASE + 2)

`endif

// ==== tb.f ====
+incdir+include
design/duc_pkg.sv
design/duc_settings.sv
design/duc_strober.sv
design/cic_interp.sv
design/cordic_rotator.sv
design/duc_chain.sv
test/duc_chain_tb.sv

// ==== test/duc_chain_tb.sv ====
// ******************************
// DUC chain testbench: clock, reset,
// LFSR stimulus, strobe model, checks
// ******************************

`timescale 1ns/1ps

`include "duc_config.svh"

module duc_chain_tb;

   localparam int CAD_LEN    = 16 * 1 + 12 * 4 + 8 * 32 + 4 * 64 + 32;  // Strobe cadence part
   localparam int DC_LEN     = 64 * 8 + 64 + 24;      // Settle at L=3, check window, writes
   localparam int MAX_CYCLES = 2 * (16 + CAD_LEN + 3 * DC_LEN);

   logic          clk;
   logic          rst;
   logic          set_stb_i;
   logic [7:0]    set_addr_i;
   logic [31:0]   set_data_i;
   logic          run_i;
   logic [31:0]   sample_i;
   logic          strobe_o;
   duc_pkg::out_t tx_i_o;
   duc_pkg::out_t tx_q_o;

   int             cycle = 0;
   logic           run_seen = 1'b0;  // Run has been high once
   logic           rc_seen;          // Rate change pulse as seen by the model
   duc_pkg::rate_t rate_l;           // Rate the strober should be using
   int             due;              // Edges until the next strobe, -1 when idle
   logic [15:0]    lfsr = 16'd51;
   logic           check_dc = 1'b0;
   logic           check_mag = 1'b0;
   longint         exp_i;
   longint         exp_q;
   longint         exp_mag;

   duc_chain i_duc_chain (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .run_i      (run_i),
      .sample_i   (sample_i),
      .strobe_o   (strobe_o),
      .tx_i_o     (tx_i_o),
      .tx_q_o     (tx_q_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "Stopped at the first failure");
   endtask

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, x^16+x^14+x^13+x^11+1
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // Magnitude between 2^13 and 2^14-1, random sign
   task automatic pick_amp(output int a);
      logic [15:0] m;
      logic [15:0] s;
      take_bits(13, m);
      take_bits(1, s);
      a = 8192 + int'(m);
      if (s[0])
         a = -a;
   endtask

   task automatic write_reg(input int addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      set_stb_i  = 1'b1;
      set_addr_i = 8'(addr);
      set_data_i = data;
      @(posedge clk);
      #1;
      set_stb_i  = 1'b0;
   endtask

   task automatic set_run(input logic level);
      @(posedge clk);
      #1 run_i = level;
   endtask

   // Counts strobe pulses as sampled on the clock edge
   task automatic wait_strobes(input int n);
      repeat (n) begin
         @(posedge clk);
         while (!strobe_o)
            @(posedge clk);
      end
   endtask

   function automatic logic near(input duc_pkg::out_t got, input longint want);
      longint d;
      d = longint'(got) - want;
      return (d <= 256) && (d >= -256);  // CORDIC error allowance
   endfunction

   function automatic logic mag_ok(input duc_pkg::out_t gi, input duc_pkg::out_t gq);
      longint m;
      longint d;
      m = longint'(gi) * gi + longint'(gq) * gq;
      d = (m > exp_mag) ? m - exp_mag : exp_mag - m;
      return d * 100 <= exp_mag;  // Within 1%
   endfunction

   // DC input at rate 8, settle 64 sample periods, then watch for 64 cycles
   task automatic settle_and_check(input logic [31:0] scale_val, input logic [31:0] inc);
      int a_i;
      int a_q;
      pick_amp(a_i);
      pick_amp(a_q);
      set_run(1'b0);  // Clears CIC and parks the NCO
      write_reg(`DUC_ADDR_RATE, 32'd3);
      write_reg(`DUC_ADDR_PHASE, inc);
      write_reg(`DUC_ADDR_SCALE, scale_val);
      sample_i = {a_i[15:0], a_q[15:0]};
      exp_i    = (longint'(a_i) * 256 * longint'(scale_val)) / 65536;  // 2 justify + 6 out bits
      exp_q    = (longint'(a_q) * 256 * longint'(scale_val)) / 65536;
      exp_mag  = (longint'(a_i) * a_i + longint'(a_q) * a_q) * 65536;
      set_run(1'b1);
      wait_strobes(64);
      #1;
      check_dc  = (inc == 0);
      check_mag = (inc != 0);
      repeat (64) @(posedge clk);
      #1;
      check_dc  = 1'b0;
      check_mag = 1'b0;
   endtask

   // Strobe timing from the run level and rate writes
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (run_i)
         run_seen <= 1'b1;
      if (rst) begin
         rc_seen <= 1'b0;
         rate_l  <= '0;
         due     <= -1;
      end else begin
         rc_seen <= set_stb_i && (set_addr_i == 8'(`DUC_ADDR_RATE));
         if (set_stb_i && (set_addr_i == 8'(`DUC_ADDR_RATE)))
            rate_l <= (set_data_i[2:0] > 3'd6) ? 3'd6 : set_data_i[2:0];  // Saturates at 64x
         if (!run_i || rc_seen)
            due <= -1;                     // Back to idle, restart one edge later
         else if (due > 0)
            due <= due - 1;
         else
            due <= (1 << rate_l) - 1;      // Start or wrap with a full period
      end
   end

   a_reset_quiet : assert property (@(posedge clk)
      (cycle >= 2 && !run_seen) |-> !strobe_o && tx_i_o == '0 && tx_q_o == '0
   ) else abort_run($sformatf("Error: strobe_o %h tx_i_o %h tx_q_o %h, expected all zero",
      $sampled(strobe_o), $sampled(tx_i_o), $sampled(tx_q_o)));

   a_strobe_timing : assert property (@(posedge clk) disable iff (rst)
      (cycle >= 2) |-> strobe_o == (due == 0)
   ) else abort_run($sformatf("Error: strobe_o %h, expected %h",
      $sampled(strobe_o), $sampled(due == 0)));

   a_dc_level : assert property (@(posedge clk) disable iff (rst)
      check_dc |-> near(tx_i_o, exp_i) && near(tx_q_o, exp_q)
   ) else abort_run($sformatf("Error: tx_i_o %h tx_q_o %h, expected %h %h",
      $sampled(tx_i_o), $sampled(tx_q_o), duc_pkg::out_t'(exp_i), duc_pkg::out_t'(exp_q)));

   a_magnitude : assert property (@(posedge clk) disable iff (rst)
      check_mag |-> mag_ok(tx_i_o, tx_q_o)
   ) else abort_run($sformatf("Error: tx_i_o %h tx_q_o %h, magnitude squared expected %h",
      $sampled(tx_i_o), $sampled(tx_q_o), exp_mag));

   initial begin
      wait (cycle >= MAX_CYCLES);
      abort_run($sformatf("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES));
   end

   initial begin
      rst        = 1'b1;
      run_i      = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      sample_i   = '0;
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      repeat (8) @(posedge clk);       // Idle after reset, run still low
      write_reg(`DUC_ADDR_RATE, 32'd0);
      set_run(1'b1);
      wait_strobes(16);
      write_reg(`DUC_ADDR_RATE, 32'd2);  // Rate changes while running
      wait_strobes(12);
      write_reg(`DUC_ADDR_RATE, 32'd5);
      wait_strobes(8);
      write_reg(`DUC_ADDR_RATE, 32'd7);  // Above the limit
      wait_strobes(4);
      settle_and_check(32'(`DUC_SCALE_ONE), 32'd0);
      settle_and_check(32'(`DUC_SCALE_ONE / 2), 32'd0);
      settle_and_check(32'(`DUC_SCALE_ONE), 32'h0123_4567);
      set_run(1'b0);
      $display("Testbench passed");
      $finish;
   end

endmodule
